// File: hazard_pkg.sv
package hazard_pkg;

  // one bit per pipeline register from PC up to WB
  typedef logic [5:0] stage_mask_t;
  // IF_ID..WB valid bits where entry i pairs with mask bit i+1
  typedef logic [4:0] valid_vec_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [31:0] addr_t;

  localparam int STG_PC    = 0;
  localparam int STG_ID_EX = 2;

  // stall/flush pairs per request source
  localparam stage_mask_t MEM_RAM_STALL    = 6'b001111;
  localparam stage_mask_t MEM_RAM_FLUSH    = 6'b010000;
  localparam stage_mask_t IF_RAM_STALL     = 6'b000011;
  localparam stage_mask_t IF_RAM_FLUSH     = 6'b000000; // nothing to kill on a fetch wait
  localparam stage_mask_t TRAP_FLUSH_STALL = 6'b000010;
  localparam stage_mask_t TRAP_FLUSH_FLUSH = 6'b001110;
  localparam stage_mask_t TRAP_STALL_STALL = 6'b111111; // freeze everything
  localparam stage_mask_t TRAP_STALL_FLUSH = 6'b001110;
  localparam stage_mask_t JUMP_STALL       = 6'b000010;
  localparam stage_mask_t JUMP_FLUSH       = 6'b000110;
  localparam stage_mask_t MULDIV_STALL     = 6'b000111;
  localparam stage_mask_t MULDIV_FLUSH     = 6'b001000; // bubble into EX_MEM
  localparam stage_mask_t LOAD_USE_STALL   = 6'b000011;
  localparam stage_mask_t LOAD_USE_FLUSH   = 6'b000100;

  // hold lengths including the issue cycle
  localparam int MUL_CYCLES = 3;
  localparam int DIV_CYCLES = 16;

  localparam int CNT_W = $clog2(DIV_CYCLES + 1);
  typedef logic [CNT_W-1:0] cycle_cnt_t;

  localparam addr_t RESET_PC = 32'h0000_0000;
  localparam addr_t PC_STEP  = 32'd4;

endpackage

// File: pipeline_control.sv
`timescale 1ns/100ps

module pipeline_control (
  input  logic                   mem_ram_stall_i,
  input  logic                   if_ram_stall_i,
  input  logic                   fetch_valid_i,
  input  logic                   trap_flush_i,
  input  logic                   trap_stall_i,
  input  logic                   jump_i,
  input  logic                   muldiv_busy_i,
  input  hazard_pkg::reg_idx_t   id_rs1_i,
  input  hazard_pkg::reg_idx_t   id_rs2_i,
  input  hazard_pkg::reg_idx_t   ex_rd_i,
  input  logic                   ex_is_load_i,
  input  hazard_pkg::valid_vec_t stage_valid_i,
  output hazard_pkg::stage_mask_t stall_o,
  output hazard_pkg::stage_mask_t flush_o,
  output logic                   redirect_trap_o,
  output logic                   redirect_jump_o
);

  import hazard_pkg::*;

  logic ex_valid;
  logic rd_match;
  logic load_use;

  assign ex_valid = stage_valid_i[STG_ID_EX-1]; // valid entries start at IF_ID
  assign rd_match = (ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i);
  // x0 never creates a dependency
  assign load_use = ex_valid && ex_is_load_i && (ex_rd_i != '0) && rd_match;

  // later stages win
  always_comb begin
    stall_o         = '0;
    flush_o         = '0;
    redirect_trap_o = 1'b0;
    redirect_jump_o = 1'b0;
    if (mem_ram_stall_i) begin
      stall_o = MEM_RAM_STALL;
      flush_o = MEM_RAM_FLUSH;
    end else if (if_ram_stall_i || !fetch_valid_i) begin
      stall_o = IF_RAM_STALL; // fetch not back yet
      flush_o = IF_RAM_FLUSH;
    end else if (trap_flush_i) begin
      stall_o         = TRAP_FLUSH_STALL;
      flush_o         = TRAP_FLUSH_FLUSH;
      redirect_trap_o = 1'b1;
    end else if (trap_stall_i) begin
      stall_o = TRAP_STALL_STALL;
      flush_o = TRAP_STALL_FLUSH;
    end else if (jump_i) begin
      stall_o         = JUMP_STALL;
      flush_o         = JUMP_FLUSH;
      redirect_jump_o = 1'b1;
    end else if (muldiv_busy_i) begin
      stall_o = MULDIV_STALL;
      flush_o = MULDIV_FLUSH;
    end else if (load_use) begin
      stall_o = LOAD_USE_STALL;
      flush_o = LOAD_USE_FLUSH;
    end
  end

endmodule

// File: muldiv_timer.sv
`timescale 1ns/100ps

module muldiv_timer (
  input  logic clk,
  input  logic rst,
  input  logic start_i,
  input  logic is_div_i,
  output logic busy_o
);

  import hazard_pkg::*;

  cycle_cnt_t count_q; // cycles left after the current one
  cycle_cnt_t load_val;
  logic       idle;
  logic       accept;

  assign idle   = (count_q == '0);
  assign accept = start_i && idle; // start while busy is dropped

  // issue cycle is already part of the hold
  assign load_val = is_div_i ? cycle_cnt_t'(DIV_CYCLES - 1)
                             : cycle_cnt_t'(MUL_CYCLES - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (accept) begin
      count_q <= load_val;
    end else if (!idle) begin
      count_q <= count_q - 1'b1;
    end
  end

  // high from the start cycle on
  assign busy_o = accept || !idle;

endmodule

// File: pipe_state_regs.sv
`timescale 1ns/100ps

module pipe_state_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  hazard_pkg::stage_mask_t stall_i,
  input  hazard_pkg::stage_mask_t flush_i,
  input  logic                    fetch_valid_i,
  input  logic                    redirect_trap_i,
  input  logic                    redirect_jump_i,
  input  hazard_pkg::addr_t       trap_vector_i,
  input  hazard_pkg::addr_t       jump_target_i,
  output hazard_pkg::addr_t       pc_o,
  output hazard_pkg::valid_vec_t  stage_valid_o
);

  import hazard_pkg::*;

  addr_t      pc_q;
  valid_vec_t valid_q;
  valid_vec_t valid_prev; // what each stage takes when it advances

  assign valid_prev = {valid_q[3:0], fetch_valid_i};

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (stall_i[STG_PC]) begin
      pc_q <= pc_q;
    end else if (redirect_trap_i) begin
      pc_q <= trap_vector_i; // trap beats jump
    end else if (redirect_jump_i) begin
      pc_q <= jump_target_i;
    end else begin
      pc_q <= pc_q + PC_STEP;
    end
  end

  // flush over stall over advance in each stage
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < 5; i++) begin
        if (flush_i[i+1]) begin
          valid_q[i] <= 1'b0;
        end else if (!stall_i[i+1]) begin
          valid_q[i] <= valid_prev[i];
        end
      end
    end
  end

  assign pc_o          = pc_q;
  assign stage_valid_o = valid_q;

endmodule

// File: pipeline_hazard_top.sv
`timescale 1ns/100ps

module pipeline_hazard_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    mem_ram_stall_i,
  input  logic                    if_ram_stall_i,
  input  logic                    fetch_valid_i,
  input  logic                    trap_flush_i,
  input  logic                    trap_stall_i,
  input  logic                    jump_i,
  input  hazard_pkg::addr_t       jump_target_i,
  input  hazard_pkg::addr_t       trap_vector_i,
  input  hazard_pkg::reg_idx_t    id_rs1_i,
  input  hazard_pkg::reg_idx_t    id_rs2_i,
  input  hazard_pkg::reg_idx_t    ex_rd_i,
  input  logic                    ex_is_load_i,
  input  logic                    muldiv_start_i,
  input  logic                    muldiv_is_div_i,
  output hazard_pkg::stage_mask_t stall_o,
  output hazard_pkg::stage_mask_t flush_o,
  output hazard_pkg::addr_t       pc_o,
  output hazard_pkg::valid_vec_t  stage_valid_o
);

  logic muldiv_busy;
  logic redirect_trap;
  logic redirect_jump;

  pipeline_control u_control (
    .mem_ram_stall_i (mem_ram_stall_i),
    .if_ram_stall_i  (if_ram_stall_i),
    .fetch_valid_i   (fetch_valid_i),
    .trap_flush_i    (trap_flush_i),
    .trap_stall_i    (trap_stall_i),
    .jump_i          (jump_i),
    .muldiv_busy_i   (muldiv_busy),
    .id_rs1_i        (id_rs1_i),
    .id_rs2_i        (id_rs2_i),
    .ex_rd_i         (ex_rd_i),
    .ex_is_load_i    (ex_is_load_i),
    .stage_valid_i   (stage_valid_o), // valid bits loop back for load-use
    .stall_o         (stall_o),
    .flush_o         (flush_o),
    .redirect_trap_o (redirect_trap),
    .redirect_jump_o (redirect_jump)
  );

  muldiv_timer u_muldiv (
    .clk      (clk),
    .rst      (rst),
    .start_i  (muldiv_start_i),
    .is_div_i (muldiv_is_div_i),
    .busy_o   (muldiv_busy)
  );

  pipe_state_regs u_state (
    .clk             (clk),
    .rst             (rst),
    .stall_i         (stall_o),
    .flush_i         (flush_o),
    .fetch_valid_i   (fetch_valid_i),
    .redirect_trap_i (redirect_trap),
    .redirect_jump_i (redirect_jump),
    .trap_vector_i   (trap_vector_i),
    .jump_target_i   (jump_target_i),
    .pc_o            (pc_o),
    .stage_valid_o   (stage_valid_o)
  );

endmodule

// File: pipeline_hazard_props.sv
`timescale 1ns/100ps

module pipeline_hazard_props (
  input logic                    clk,
  input logic                    rst,
  input logic                    mem_ram_stall_i,
  input logic                    if_ram_stall_i,
  input logic                    fetch_valid_i,
  input logic                    trap_flush_i,
  input logic                    trap_stall_i,
  input hazard_pkg::stage_mask_t stall_i,
  input hazard_pkg::stage_mask_t flush_i,
  input hazard_pkg::valid_vec_t  stage_valid_i
);

  int unsigned fail_cnt = 0;

  // first edge after reset sees cleared valid bits
  a_reset_clear: assert property (@(posedge clk) (!rst && $past(rst)) |-> stage_valid_i == '0)
    else begin
      fail_cnt++;
      $error("valid bits not zero after reset");
    end

  a_flush_clear: assert property (@(posedge clk) disable iff (rst)
    (flush_i[5:1] != '0) |=> ((stage_valid_i & $past(flush_i[5:1])) == '0))
    else begin
      fail_cnt++;
      $error("flushed stage still valid one cycle later");
    end

  // trap stall wins only below the memory and fetch waits and trap flush
  a_trap_freeze: assert property (@(posedge clk) disable iff (rst)
    (trap_stall_i && !mem_ram_stall_i && !if_ram_stall_i && fetch_valid_i && !trap_flush_i)
      |-> stall_i == 6'b111111)
    else begin
      fail_cnt++;
      $error("trap stall did not freeze every stage");
    end

endmodule

bind pipeline_hazard_top pipeline_hazard_props u_props (
  .clk             (clk),
  .rst             (rst),
  .mem_ram_stall_i (mem_ram_stall_i),
  .if_ram_stall_i  (if_ram_stall_i),
  .fetch_valid_i   (fetch_valid_i),
  .trap_flush_i    (trap_flush_i),
  .trap_stall_i    (trap_stall_i),
  .stall_i         (stall_o),
  .flush_i         (flush_o),
  .stage_valid_i   (stage_valid_o)
);

// File: tb_pipeline_hazard.sv
`timescale 1ns/100ps

module tb_pipeline_hazard;

  import hazard_pkg::*;

  localparam int MAX_CYCLES = 2000; // tests use about 400 cycles

  logic        clk;
  logic        rst;
  logic        mem_ram_stall;
  logic        if_ram_stall;
  logic        fetch_valid;
  logic        trap_flush;
  logic        trap_stall;
  logic        jump;
  addr_t       jump_target;
  addr_t       trap_vector;
  reg_idx_t    id_rs1;
  reg_idx_t    id_rs2;
  reg_idx_t    ex_rd;
  logic        ex_is_load;
  logic        muldiv_start;
  logic        muldiv_is_div;
  stage_mask_t stall;
  stage_mask_t flush;
  addr_t       pc;
  valid_vec_t  stage_valid;

  int          err_cnt = 0;
  int          cycle_cnt = 0;
  int          total;
  logic [31:0] lcg_state = 32'hd72c6e59;

  pipeline_hazard_top u_pipeline_hazard_top (
    .clk             (clk),
    .rst             (rst),
    .mem_ram_stall_i (mem_ram_stall),
    .if_ram_stall_i  (if_ram_stall),
    .fetch_valid_i   (fetch_valid),
    .trap_flush_i    (trap_flush),
    .trap_stall_i    (trap_stall),
    .jump_i          (jump),
    .jump_target_i   (jump_target),
    .trap_vector_i   (trap_vector),
    .id_rs1_i        (id_rs1),
    .id_rs2_i        (id_rs2),
    .ex_rd_i         (ex_rd),
    .ex_is_load_i    (ex_is_load),
    .muldiv_start_i  (muldiv_start),
    .muldiv_is_div_i (muldiv_is_div),
    .stall_o         (stall),
    .flush_o         (flush),
    .pc_o            (pc),
    .stage_valid_o   (stage_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // request bit order is mem, if/fetch, trap flush, trap stall, jump, muldiv, load-use
  function automatic int top_request(logic [6:0] req);
    for (int i = 0; i < 7; i++) begin
      if (req[i]) return i;
    end
    return 7;
  endfunction

  function automatic stage_mask_t ref_stall(int idx);
    case (idx)
      0: return 6'b001111;
      1: return 6'b000011;
      2: return 6'b000010;
      3: return 6'b111111;
      4: return 6'b000010;
      5: return 6'b000111;
      6: return 6'b000011;
      default: return 6'b000000;
    endcase
  endfunction

  function automatic stage_mask_t ref_flush(int idx);
    case (idx)
      0: return 6'b010000;
      2: return 6'b001110;
      3: return 6'b001110;
      4: return 6'b000110;
      5: return 6'b001000;
      6: return 6'b000100;
      default: return 6'b000000;
    endcase
  endfunction

  task automatic check_mask(string name, stage_mask_t exp, stage_mask_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_valid(string name, valid_vec_t exp, valid_vec_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_pair(string name, logic [6:0] req);
    int idx;
    idx = top_request(req);
    check_mask({name, " stall"}, ref_stall(idx), stall);
    check_mask({name, " flush"}, ref_flush(idx), flush);
  endtask

  task automatic drive_idle();
    mem_ram_stall = 1'b0;
    if_ram_stall  = 1'b0;
    fetch_valid   = 1'b1;
    trap_flush    = 1'b0;
    trap_stall    = 1'b0;
    jump          = 1'b0;
    muldiv_start  = 1'b0;
    muldiv_is_div = 1'b0;
    ex_is_load    = 1'b0;
  endtask

  // idle until the masks stay zero long enough for ID_EX to refill
  task automatic settle(int quiet_needed);
    int quiet;
    quiet = 0;
    while (quiet < quiet_needed) begin
      @(negedge clk);
      drive_idle();
      #1;
      if (stall == '0 && flush == '0) quiet++;
      else quiet = 0;
    end
  endtask

  task automatic drive_requests(logic [6:0] req);
    logic [31:0] pick;
    pick = next_rand();
    drive_idle();
    mem_ram_stall = req[0];
    if (req[1]) begin
      if (pick[20]) if_ram_stall = 1'b1;
      else fetch_valid = 1'b0;
    end
    trap_flush   = req[2];
    trap_stall   = req[3];
    jump         = req[4];
    muldiv_start = req[5];
    if (req[6]) begin
      ex_is_load = 1'b1;
      ex_rd      = reg_idx_t'(((pick >> 8) % 31) + 1);
      id_rs1     = ex_rd;
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic reset_free_run();
    valid_vec_t exp_valid;
    addr_t      exp_pc;
    exp_valid = '0;
    exp_pc    = 32'h0000_0000;
    check_addr("reset pc", exp_pc, pc);
    check_valid("reset valid", exp_valid, stage_valid);
    for (int k = 0; k < 7; k++) begin
      @(negedge clk);
      exp_pc    = exp_pc + 32'd4;
      exp_valid = valid_vec_t'((32'd1 << (k + 1)) - 1); // one stage per cycle
      check_addr("free run pc", exp_pc, pc);
      check_valid("free run valid", exp_valid, stage_valid);
    end
  endtask

  task automatic priority_order();
    logic [6:0]  req;
    int unsigned a;
    int unsigned b;
    for (int k = 0; k < 7; k++) begin
      settle(3);
      @(negedge clk);
      req = 7'b1 << k;
      drive_requests(req);
      #1;
      check_pair("priority single", req);
    end
    settle(3);
    @(negedge clk);
    if_ram_stall = 1'b1;
    #1;
    check_pair("priority if stall", 7'b0000010);
    settle(3);
    @(negedge clk);
    fetch_valid = 1'b0; // fetch wait without a RAM stall
    #1;
    check_pair("priority fetch wait", 7'b0000010);
    for (int n = 0; n < 20; n++) begin
      a = (next_rand() >> 16) % 7;
      b = (next_rand() >> 16) % 7;
      if (a == b) b = (a + 1) % 7;
      req    = '0;
      req[a] = 1'b1;
      req[b] = 1'b1;
      settle(3);
      @(negedge clk);
      drive_requests(req);
      #1;
      check_pair("priority pair", req);
    end
  endtask

  task automatic drive_load(string name, logic is_load, reg_idx_t rd, reg_idx_t rs1,
                            reg_idx_t rs2, logic [6:0] exp_req);
    settle(3);
    @(negedge clk);
    ex_is_load = is_load;
    ex_rd      = rd;
    id_rs1     = rs1;
    id_rs2     = rs2;
    #1;
    check_pair(name, exp_req);
  endtask

  task automatic load_use_detect();
    reg_idx_t rd;
    rd = reg_idx_t'(((next_rand() >> 8) % 31) + 1);
    drive_load("load_use rs1", 1'b1, rd, rd, rd + 5'd1, 7'b1000000);
    drive_load("load_use rs2", 1'b1, rd, rd + 5'd1, rd, 7'b1000000);
    drive_load("load_use x0", 1'b1, 5'd0, 5'd0, 5'd0, 7'b0);
    drive_load("load_use no load", 1'b0, rd, rd, rd, 7'b0);
  endtask

  task automatic muldiv_hold(string name, logic is_div, int cycles);
    settle(3);
    @(negedge clk);
    muldiv_start  = 1'b1;
    muldiv_is_div = is_div;
    for (int k = 0; k < cycles; k++) begin
      #1;
      check_pair(name, 7'b0100000);
      @(negedge clk);
      drive_idle();
      muldiv_start  = (k == 0); // restart while busy must be dropped
      muldiv_is_div = 1'b1;
    end
    #1;
    check_pair({name, " done"}, 7'b0);
  endtask

  task automatic redirect_pc();
    addr_t target;
    addr_t vector;
    settle(3);
    target = next_rand() & 32'hffff_fffc;
    @(negedge clk);
    jump        = 1'b1;
    jump_target = target;
    @(negedge clk);
    drive_idle();
    check_addr("jump pc", target, pc);
    check_valid("jump id_ex", '0, stage_valid & 5'b00010);
    settle(3);
    target = next_rand() & 32'hffff_fffc;
    vector = next_rand() & 32'hffff_fffc;
    @(negedge clk);
    trap_flush  = 1'b1;
    trap_vector = vector;
    jump        = 1'b1;
    jump_target = target;
    @(negedge clk);
    drive_idle();
    check_addr("trap over jump pc", vector, pc);
    check_valid("trap flushed stages", '0, stage_valid & 5'b00111);
  endtask

  task automatic mem_stall_hold();
    addr_t target;
    settle(3);
    target = next_rand() & 32'hffff_fffc;
    @(negedge clk);
    jump        = 1'b1;
    jump_target = target;
    repeat (6) begin // jump edge and five free cycles fill every stage
      @(negedge clk);
      drive_idle();
    end
    check_addr("pre stall pc", target + 32'd20, pc);
    check_valid("pre stall valid", 5'b11111, stage_valid);
    mem_ram_stall = 1'b1;
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      check_addr("mem stall pc", target + 32'd20, pc);
      // WB still drains the old MEM_WB once
      check_valid("mem stall valid", (k == 0) ? 5'b10111 : 5'b00111, stage_valid);
    end
    drive_idle();
  endtask

  initial begin
    rst         = 1'b1;
    jump_target = '0;
    trap_vector = '0;
    id_rs1      = '0;
    id_rs2      = '0;
    ex_rd       = '0;
    drive_idle();
    apply_reset();
    reset_free_run();
    priority_order();
    load_use_detect();
    muldiv_hold("mul hold", 1'b0, MUL_CYCLES);
    muldiv_hold("div hold", 1'b1, DIV_CYCLES);
    redirect_pc();
    mem_stall_hold();
    total = err_cnt + u_pipeline_hazard_top.u_props.fail_cnt;
    $display("check errors %0d, assertion errors %0d", err_cnt,
             u_pipeline_hazard_top.u_props.fail_cnt);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: filelist.f
hazard_pkg.sv
pipeline_control.sv
muldiv_timer.sv
pipe_state_regs.sv
pipeline_hazard_top.sv
pipeline_hazard_props.sv
tb_pipeline_hazard.sv

// File: Makefile
TOP := tb_pipeline_hazard

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
